//--- design/core_pkg.sv
package core_pkg;

  // data and result words
  typedef logic [31:0] word_t;

  // instruction address
  typedef logic [31:0] pc_t;

  // general register index, 32 registers
  typedef logic [4:0] reg_addr_t;

  // CSR number
  typedef logic [13:0] csr_addr_t;

  // implemented CSR numbers
  localparam csr_addr_t CSR_CRMD = 14'h000;
  localparam csr_addr_t CSR_PRMD = 14'h001;
  localparam csr_addr_t CSR_ERA = 14'h006;

  // first of the scratch SAVE registers, the rest follow contiguously
  localparam csr_addr_t CSR_SAVE_BASE = 14'h030;

endpackage

//--- design/bus_pkg.sv
package bus_pkg;

  // bit 1 = stage holds an instruction, bit 0 = not cancelled
  typedef logic [1:0] lane_valid_t;

  // one lane handed over by execute
  typedef struct packed {
    logic                 csr_we;
    core_pkg::csr_addr_t  csr_addr;
    core_pkg::word_t      csr_wdata;
    logic                 gr_we;
    core_pkg::reg_addr_t  dest;
    core_pkg::word_t      result;
    core_pkg::pc_t        pc;
  } ex_to_wb_t;

  // bypass info back to execute
  typedef struct packed {
    logic                 live;
    logic                 csr_we;
    core_pkg::csr_addr_t  csr_addr;
    core_pkg::word_t      csr_wdata;
    logic                 gr_we;
    core_pkg::reg_addr_t  dest;
    core_pkg::word_t      result;
  } forward_t;

  // qualified register write of one lane
  typedef struct packed {
    logic                 we;
    core_pkg::reg_addr_t  addr;
    core_pkg::word_t      data;
    core_pkg::pc_t        pc;
  } rf_write_t;

  // the single selected CSR write
  typedef struct packed {
    logic                 we;
    core_pkg::csr_addr_t  addr;
    core_pkg::word_t      data;
  } csr_write_t;

  // retired instruction record for co-simulation
  typedef struct packed {
    logic                 valid;
    core_pkg::pc_t        pc;
    logic                 rf_we;
    core_pkg::reg_addr_t  dest;
    core_pkg::word_t      result;
  } commit_t;

endpackage

//--- design/wb_stage.sv
`timescale 1ns/1ns

module wb_stage (
  input  bus_pkg::ex_to_wb_t   lane1,
  input  bus_pkg::ex_to_wb_t   lane2,
  input  bus_pkg::lane_valid_t valid1,
  input  bus_pkg::lane_valid_t valid2,
  input  logic                 nblock1,
  input  logic                 nblock2,
  output logic                 ready,
  output bus_pkg::forward_t    fwd1,
  output bus_pkg::forward_t    fwd2,
  output bus_pkg::rf_write_t   rf_wr1,
  output bus_pkg::rf_write_t   rf_wr2,
  output bus_pkg::csr_write_t  csr_wr
);

  logic commit1;
  logic commit2;
  logic same_dest;

  // a lane retires only when present and not cancelled
  assign commit1 = valid1[1] & valid1[0];
  assign commit2 = valid2[1] & valid2[0];

  // no internal state, so ready just mirrors the downstream blocks
  assign ready = nblock1 & nblock2;

  assign fwd1 = '{live: valid1[0], csr_we: lane1.csr_we, csr_addr: lane1.csr_addr,
                  csr_wdata: lane1.csr_wdata, gr_we: lane1.gr_we, dest: lane1.dest,
                  result: lane1.result};
  assign fwd2 = '{live: valid2[0], csr_we: lane2.csr_we, csr_addr: lane2.csr_addr,
                  csr_wdata: lane2.csr_wdata, gr_we: lane2.gr_we, dest: lane2.dest,
                  result: lane2.result};

  // lane 2 is younger and wins a shared destination
  assign rf_wr2.we   = lane2.gr_we & commit2;
  assign rf_wr2.addr = lane2.dest;
  assign rf_wr2.data = lane2.result;
  assign rf_wr2.pc   = lane2.pc;

  assign same_dest   = (lane1.dest == lane2.dest);

  assign rf_wr1.we   = lane1.gr_we & commit1 & ~(same_dest & rf_wr2.we);
  assign rf_wr1.addr = lane1.dest;
  assign rf_wr1.data = lane1.result;
  assign rf_wr1.pc   = lane1.pc;

  // one CSR port, older lane first
  always_comb begin
    csr_wr = '0;
    if (lane1.csr_we) begin
      csr_wr.we   = commit1;
      csr_wr.addr = lane1.csr_addr;
      csr_wr.data = lane1.csr_wdata;
    end else if (lane2.csr_we) begin
      // lane 2 may only touch a CSR once lane 1 has retired too
      csr_wr.we   = commit1 & commit2;
      csr_wr.addr = lane2.csr_addr;
      csr_wr.data = lane2.csr_wdata;
    end
  end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic                clk,
  input  logic                reset,
  input  bus_pkg::rf_write_t  wr1,
  input  bus_pkg::rf_write_t  wr2,
  input  core_pkg::reg_addr_t raddr1,
  input  core_pkg::reg_addr_t raddr2,
  output core_pkg::word_t     rdata1,
  output core_pkg::word_t     rdata2
);

  core_pkg::word_t regs [32];

  // both ports write on the same edge, writes to r0 dropped
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr1.we && wr1.addr != '0) begin
        regs[wr1.addr] <= wr1.data;
      end
      // lane 2 last, so it would win if the stage ever let both through
      if (wr2.we && wr2.addr != '0) begin
        regs[wr2.addr] <= wr2.data;
      end
    end
  end

  // no write bypass
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- design/csr_file.sv
`timescale 1ns/1ns

module csr_file #(
  parameter int SAVE_COUNT = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  bus_pkg::csr_write_t  wr,
  input  core_pkg::csr_addr_t  raddr,
  output core_pkg::word_t      rdata
);

  localparam int IDX_W = (SAVE_COUNT > 1) ? $clog2(SAVE_COUNT) : 1;
  localparam core_pkg::csr_addr_t SAVE_END =
    core_pkg::CSR_SAVE_BASE + core_pkg::csr_addr_t'(SAVE_COUNT);

  core_pkg::word_t crmd;
  core_pkg::word_t prmd;
  core_pkg::word_t era;
  core_pkg::word_t save [SAVE_COUNT];

  core_pkg::csr_addr_t wr_off;
  core_pkg::csr_addr_t rd_off;
  logic                wr_save;
  logic                rd_save;

  // SAVE window decode
  assign wr_off  = wr.addr - core_pkg::CSR_SAVE_BASE;
  assign rd_off  = raddr - core_pkg::CSR_SAVE_BASE;
  assign wr_save = (wr.addr >= core_pkg::CSR_SAVE_BASE) && (wr.addr < SAVE_END);
  assign rd_save = (raddr >= core_pkg::CSR_SAVE_BASE) && (raddr < SAVE_END);

  always_ff @(posedge clk) begin
    if (reset) begin
      crmd <= '0;
      prmd <= '0;
      era  <= '0;
      for (int i = 0; i < SAVE_COUNT; i++) begin
        save[i] <= '0;
      end
    end else if (wr.we) begin
      // unimplemented numbers fall through and are ignored
      if (wr.addr == core_pkg::CSR_CRMD) crmd <= wr.data;
      if (wr.addr == core_pkg::CSR_PRMD) prmd <= wr.data;
      if (wr.addr == core_pkg::CSR_ERA) era <= wr.data;
      if (wr_save) save[wr_off[IDX_W-1:0]] <= wr.data;
    end
  end

  always_comb begin
    rdata = '0;
    if (raddr == core_pkg::CSR_CRMD) rdata = crmd;
    if (raddr == core_pkg::CSR_PRMD) rdata = prmd;
    if (raddr == core_pkg::CSR_ERA) rdata = era;
    if (rd_save) rdata = save[rd_off[IDX_W-1:0]];
  end

endmodule

//--- design/commit_trace.sv
`timescale 1ns/1ns

module commit_trace (
  input  logic                 clk,
  input  logic                 reset,
  input  bus_pkg::rf_write_t   wr1,
  input  bus_pkg::rf_write_t   wr2,
  input  bus_pkg::lane_valid_t valid1,
  input  bus_pkg::lane_valid_t valid2,
  input  bus_pkg::ex_to_wb_t   lane1,
  input  bus_pkg::ex_to_wb_t   lane2,
  output bus_pkg::commit_t     trace1,
  output bus_pkg::commit_t     trace2
);

  // record from the lane's commit state and its qualified write
  function automatic bus_pkg::commit_t make_record(bus_pkg::lane_valid_t v,
                                                   bus_pkg::ex_to_wb_t l,
                                                   bus_pkg::rf_write_t w);
    bus_pkg::commit_t rec;
    rec.valid  = v[1] & v[0];
    rec.pc     = l.pc;
    rec.rf_we  = w.we;
    rec.dest   = w.addr;
    rec.result = w.data;
    return rec;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      trace1 <= '0;
      trace2 <= '0;
    end else begin
      trace1 <= make_record(valid1, lane1, wr1);
      trace2 <= make_record(valid2, lane2, wr2);
    end
  end

endmodule

//--- design/wb_subsystem.sv
`timescale 1ns/1ns

module wb_subsystem #(
  parameter int SAVE_COUNT = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  bus_pkg::ex_to_wb_t   lane1,
  input  bus_pkg::ex_to_wb_t   lane2,
  input  bus_pkg::lane_valid_t valid1,
  input  bus_pkg::lane_valid_t valid2,
  input  logic                 nblock1,
  input  logic                 nblock2,
  input  core_pkg::reg_addr_t  rf_raddr1,
  input  core_pkg::reg_addr_t  rf_raddr2,
  input  core_pkg::csr_addr_t  csr_raddr,
  output logic                 ready,
  output bus_pkg::forward_t    fwd1,
  output bus_pkg::forward_t    fwd2,
  output core_pkg::word_t      rf_rdata1,
  output core_pkg::word_t      rf_rdata2,
  output core_pkg::word_t      csr_rdata,
  output bus_pkg::commit_t     trace1,
  output bus_pkg::commit_t     trace2
);

  bus_pkg::rf_write_t  rf_wr1;
  bus_pkg::rf_write_t  rf_wr2;
  bus_pkg::csr_write_t csr_wr;

  wb_stage u_wb_stage (
    .lane1   (lane1),
    .lane2   (lane2),
    .valid1  (valid1),
    .valid2  (valid2),
    .nblock1 (nblock1),
    .nblock2 (nblock2),
    .ready   (ready),
    .fwd1    (fwd1),
    .fwd2    (fwd2),
    .rf_wr1  (rf_wr1),
    .rf_wr2  (rf_wr2),
    .csr_wr  (csr_wr)
  );

  reg_file u_reg_file (
    .clk    (clk),
    .reset  (reset),
    .wr1    (rf_wr1),
    .wr2    (rf_wr2),
    .raddr1 (rf_raddr1),
    .raddr2 (rf_raddr2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2)
  );

  csr_file #(
    .SAVE_COUNT (SAVE_COUNT)
  ) u_csr_file (
    .clk   (clk),
    .reset (reset),
    .wr    (csr_wr),
    .raddr (csr_raddr),
    .rdata (csr_rdata)
  );

  // trace sees the same qualified writes as the register file
  commit_trace u_commit_trace (
    .clk    (clk),
    .reset  (reset),
    .wr1    (rf_wr1),
    .wr2    (rf_wr2),
    .valid1 (valid1),
    .valid2 (valid2),
    .lane1  (lane1),
    .lane2  (lane2),
    .trace1 (trace1),
    .trace2 (trace2)
  );

endmodule

//--- tests/wb_properties.sv
`timescale 1ns/1ns

module wb_properties (
  input logic                 clk,
  input logic                 reset,
  input bus_pkg::lane_valid_t valid1,
  input logic                 nblock1,
  input logic                 nblock2,
  input logic                 ready,
  input bus_pkg::rf_write_t   rf_wr1,
  input bus_pkg::rf_write_t   rf_wr2,
  input bus_pkg::csr_write_t  csr_wr
);

  // younger lane takes a shared destination
  no_dual_write: assert property (@(posedge clk) disable iff (reset)
    !(rf_wr1.we && rf_wr2.we && rf_wr1.addr == rf_wr2.addr))
    else $error("both register write ports target register %0d", rf_wr1.addr);

  // any CSR write needs lane 1 retiring
  csr_needs_lane1: assert property (@(posedge clk) disable iff (reset)
    csr_wr.we |-> (valid1 == 2'b11))
    else $error("CSR write while lane 1 is not committing");

  ready_is_and: assert property (@(posedge clk) ready == (nblock1 & nblock2))
    else $error("ready differs from nblock1 and nblock2");

endmodule

// wb_stage has no clock, so the checker sits in the top level next to it
bind wb_subsystem wb_properties props0 (
  .clk     (clk),
  .reset   (reset),
  .valid1  (valid1),
  .nblock1 (nblock1),
  .nblock2 (nblock2),
  .ready   (ready),
  .rf_wr1  (rf_wr1),
  .rf_wr2  (rf_wr2),
  .csr_wr  (csr_wr)
);

//--- tests/tb_wb_subsystem.sv
`timescale 1ns/1ns

module tb_wb_subsystem;

  // one golden line
  // lane flags are {csr_we, gr_we, valid[1:0]}
  typedef struct packed {
    logic [3:0]  flags1;
    logic [4:0]  dest1;
    logic [31:0] result1;
    logic [13:0] csr1;
    logic [3:0]  flags2;
    logic [4:0]  dest2;
    logic [31:0] result2;
    logic [13:0] csr2;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [13:0] csr_raddr;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] csr_rdata;
    logic [3:0]  trace_flags;
    logic [31:0] tres1;
    logic [31:0] tres2;
  } step_t;

  logic                 clk;
  logic                 reset;
  bus_pkg::ex_to_wb_t   lane1;
  bus_pkg::ex_to_wb_t   lane2;
  bus_pkg::lane_valid_t valid1;
  bus_pkg::lane_valid_t valid2;
  logic                 nblock1;
  logic                 nblock2;
  core_pkg::reg_addr_t  rf_raddr1;
  core_pkg::reg_addr_t  rf_raddr2;
  core_pkg::csr_addr_t  csr_raddr;
  logic                 ready;
  bus_pkg::forward_t    fwd1;
  bus_pkg::forward_t    fwd2;
  core_pkg::word_t      rf_rdata1;
  core_pkg::word_t      rf_rdata2;
  core_pkg::word_t      csr_rdata;
  bus_pkg::commit_t     trace1;
  bus_pkg::commit_t     trace2;

  step_t steps [64];
  int    n_steps;
  int    step_no;
  int    errors;
  int    cycles;
  int    limit = 36;
  int    seed;

  wb_subsystem #(
    .SAVE_COUNT (4)
  ) dut0 (
    .clk       (clk),
    .reset     (reset),
    .lane1     (lane1),
    .lane2     (lane2),
    .valid1    (valid1),
    .valid2    (valid2),
    .nblock1   (nblock1),
    .nblock2   (nblock2),
    .rf_raddr1 (rf_raddr1),
    .rf_raddr2 (rf_raddr2),
    .csr_raddr (csr_raddr),
    .ready     (ready),
    .fwd1      (fwd1),
    .fwd2      (fwd2),
    .rf_rdata1 (rf_rdata1),
    .rf_rdata2 (rf_rdata2),
    .csr_rdata (csr_rdata),
    .trace1    (trace1),
    .trace2    (trace2)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // limit is raised once the golden file has been counted
  initial begin
    cycles = 0;
    while (cycles <= limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the run did not finish within %0d cycles", limit);
    $display("Errors found");
    $finish;
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("Fail %s (step %0d): got %0h, expected %0h", name, step_no, got, exp);
      errors++;
    end
  endtask

  // made-up pc with lane 2 one word above lane 1
  function automatic core_pkg::pc_t lane_pc(input int idx, input int lane);
    return 32'h1c00_0000 + 32'(idx * 8 + lane * 4);
  endfunction

  task automatic check_lane_forward(input string tag, input bus_pkg::forward_t f,
                                    input bus_pkg::ex_to_wb_t l,
                                    input bus_pkg::lane_valid_t v);
    check_value({tag, ".live"}, f.live, v[0]);
    check_value({tag, ".csr_we"}, f.csr_we, l.csr_we);
    check_value({tag, ".csr_addr"}, f.csr_addr, l.csr_addr);
    check_value({tag, ".csr_wdata"}, f.csr_wdata, l.csr_wdata);
    check_value({tag, ".gr_we"}, f.gr_we, l.gr_we);
    check_value({tag, ".dest"}, f.dest, l.dest);
    check_value({tag, ".result"}, f.result, l.result);
  endtask

  // CSR lanes write the golden result, other lanes carry its inverse
  task automatic drive_step(input step_t s, input int idx);
    lane1 <= '{csr_we: s.flags1[3], csr_addr: s.csr1,
               csr_wdata: s.flags1[3] ? s.result1 : ~s.result1,
               gr_we: s.flags1[2], dest: s.dest1, result: s.result1, pc: lane_pc(idx, 0)};
    lane2 <= '{csr_we: s.flags2[3], csr_addr: s.csr2,
               csr_wdata: s.flags2[3] ? s.result2 : ~s.result2,
               gr_we: s.flags2[2], dest: s.dest2, result: s.result2, pc: lane_pc(idx, 1)};
    valid1    <= s.flags1[1:0];
    valid2    <= s.flags2[1:0];
    rf_raddr1 <= s.raddr1;
    rf_raddr2 <= s.raddr2;
    csr_raddr <= s.csr_raddr;
    nblock1   <= 1'($random(seed));
    nblock2   <= 1'($random(seed));
  endtask

  task automatic check_result(input step_t s, input int idx);
    check_value("rf_rdata1", rf_rdata1, s.rdata1);
    check_value("rf_rdata2", rf_rdata2, s.rdata2);
    check_value("csr_rdata", csr_rdata, s.csr_rdata);
    check_value("trace1.valid", trace1.valid, s.trace_flags[0]);
    check_value("trace1.rf_we", trace1.rf_we, s.trace_flags[1]);
    check_value("trace1.dest", trace1.dest, s.dest1);
    check_value("trace1.result", trace1.result, s.tres1);
    check_value("trace1.pc", trace1.pc, lane_pc(idx, 0));
    check_value("trace2.valid", trace2.valid, s.trace_flags[2]);
    check_value("trace2.rf_we", trace2.rf_we, s.trace_flags[3]);
    check_value("trace2.dest", trace2.dest, s.dest2);
    check_value("trace2.result", trace2.result, s.tres2);
    check_value("trace2.pc", trace2.pc, lane_pc(idx, 1));
  endtask

  initial begin
    int          fd;
    int          got;
    string       line;
    logic [31:0] col [17];
    errors    = 0;
    step_no   = 0;
    n_steps   = 0;
    seed      = 89;
    reset     = 1'b1;
    lane1     = '0;
    lane2     = '0;
    valid1    = '0;
    valid2    = '0;
    nblock1   = 1'b1;
    nblock2   = 1'b1;
    rf_raddr1 = 5'd31;
    rf_raddr2 = 5'd1;
    csr_raddr = core_pkg::CSR_PRMD;
    fd = $fopen("tests/wb_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file tests/wb_golden.txt");
      errors++;
    end else begin
      while (!$feof(fd) && n_steps < 64) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                        col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                        col[15], col[16]);
          if (got != 17) begin
            $display("golden line has %0d fields instead of 17: %s", got, line);
            errors++;
          end else begin
            steps[n_steps] = {col[0][3:0], col[1][4:0], col[2], col[3][13:0],
                              col[4][3:0], col[5][4:0], col[6], col[7][13:0],
                              col[8][4:0], col[9][4:0], col[10][13:0], col[11], col[12],
                              col[13], col[14][3:0], col[15], col[16]};
            n_steps++;
          end
        end
      end
      $fclose(fd);
    end
    limit = 16 + 4 * n_steps + 20;

    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("trace1", trace1, '0);
    check_value("trace2", trace2, '0);
    check_value("rf_rdata1", rf_rdata1, '0);
    check_value("rf_rdata2", rf_rdata2, '0);
    check_value("csr_rdata", csr_rdata, '0);

    // each step drives the lanes for one cycle and reads back in an idle one
    for (int i = 0; i < n_steps; i++) begin
      step_no = i + 1;
      @(posedge clk);
      drive_step(steps[i], i);
      @(negedge clk);
      check_lane_forward("fwd1", fwd1, lane1, valid1);
      check_lane_forward("fwd2", fwd2, lane2, valid2);
      check_value("ready", ready, nblock1 & nblock2);
      @(posedge clk);
      valid1 <= '0;
      valid2 <= '0;
      @(negedge clk);
      check_result(steps[i], i);
    end

    @(posedge clk);
    $display("%0d golden steps run, %0d error(s)", n_steps, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- tests/wb_golden.txt
# per lane: flags{csr_we,gr_we,valid[1:0]} dest result csr_addr, lane 1 then lane 2
# then raddr1 raddr2 csr_raddr, rdata1 rdata2 csr_rdata, trace{we2,v2,we1,v1} tres1 tres2
7 01 00000011 000 0 00 00000000 000 01 00 000 00000011 00000000 00000000 3 00000011 00000000
7 00 deadbeef 000 7 02 00000022 000 00 02 000 00000000 00000022 00000000 f deadbeef 00000022
7 03 00000033 000 7 03 00000034 000 03 01 000 00000034 00000011 00000000 d 00000033 00000034
7 04 00000044 000 7 05 00000055 000 04 05 000 00000044 00000055 00000000 f 00000044 00000055
6 06 00000066 000 0 00 00000000 000 06 03 000 00000000 00000034 00000000 0 00000066 00000000
5 01 0000ffff 000 6 02 0000eeee 000 01 02 000 00000011 00000022 00000000 0 0000ffff 0000eeee
7 05 00000077 000 6 05 00000078 000 05 04 000 00000077 00000044 00000000 3 00000077 00000078
b 00 a1a1a1a1 001 b 00 b2b2b2b2 001 01 02 001 00000011 00000022 a1a1a1a1 5 a1a1a1a1 b2b2b2b2
a 00 c3c3c3c3 006 b 00 d4d4d4d4 006 01 02 006 00000011 00000022 00000000 4 c3c3c3c3 d4d4d4d4
3 00 00000001 000 b 00 e5e5e5e5 006 01 02 006 00000011 00000022 e5e5e5e5 5 00000001 e5e5e5e5
2 00 00000002 000 b 00 f6f6f6f6 000 01 02 000 00000011 00000022 00000000 4 00000002 f6f6f6f6
0 00 00000000 000 b 00 f6f6f6f6 000 01 02 000 00000011 00000022 00000000 4 00000000 f6f6f6f6
f 08 12345678 030 0 00 00000000 000 08 00 030 12345678 00000000 12345678 3 12345678 00000000
7 09 00000099 000 b 00 87654321 033 09 08 033 00000099 12345678 87654321 7 00000099 87654321
b 00 55aa55aa 034 0 00 00000000 000 01 02 034 00000011 00000022 00000000 1 55aa55aa 00000000
b 00 66bb66bb 005 0 00 00000000 000 01 02 005 00000011 00000022 00000000 1 66bb66bb 00000000
0 00 00000000 000 0 00 00000000 000 03 05 001 00000034 00000077 a1a1a1a1 0 00000000 00000000
0 00 00000000 000 0 00 00000000 000 1f 02 006 00000000 00000022 e5e5e5e5 0 00000000 00000000
6 1f 0000aaaa 000 7 1f 0000bbbb 000 1f 01 030 0000bbbb 00000011 12345678 c 0000aaaa 0000bbbb
7 1f 0000cccc 000 3 1f 0000dddd 000 1f 09 033 0000cccc 00000099 87654321 7 0000cccc 0000dddd
7 02 22222222 000 7 01 11111111 000 01 02 000 11111111 22222222 00000000 f 22222222 11111111
f 0a 0a0a0a0a 000 f 0a 0b0b0b0b 001 0a 00 000 0b0b0b0b 00000000 0a0a0a0a d 0a0a0a0a 0b0b0b0b
0 00 00000000 000 0 00 00000000 000 0a 1f 001 0b0b0b0b 0000cccc a1a1a1a1 0 00000000 00000000

//--- files.f
design/core_pkg.sv
design/bus_pkg.sv
design/wb_stage.sv
design/reg_file.sv
design/csr_file.sv
design/commit_trace.sv
design/wb_subsystem.sv
tests/wb_properties.sv
tests/tb_wb_subsystem.sv

//--- Bender.yml
package:
  name: wb_subsystem

sources:
  - files:
      - design/core_pkg.sv
      - design/bus_pkg.sv
      - design/wb_stage.sv
      - design/reg_file.sv
      - design/csr_file.sv
      - design/commit_trace.sv
      - design/wb_subsystem.sv
  - target: test
    files:
      - tests/wb_properties.sv
      - tests/tb_wb_subsystem.sv
